// ==== build.f ====
hw/ras_pkg.sv
hw/call_return_decode.sv
hw/ras_checkpoint_fifo.sv
hw/return_stack.sv
hw/return_predictor.sv
sim/return_predictor_assertions.sv
sim/return_predictor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the return predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ_DIR=obj_dir
BIN=sim_return_predictor

verilator --binary --timing --assert \
    --top-module return_predictor_tb \
    --Mdir "$OBJ_DIR" \
    -o "$BIN" \
    -f build.f

# Keep going on a failing run so that its log gets searched
"./$OBJ_DIR/$BIN" +verilator+error+limit+100 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== sim/return_predictor_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Return predictor testbench
// Directed and random fetch streams against a reference stack model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module return_predictor_tb
    import ras_pkg::*;
();

    localparam int RAS_ENTRIES     = 8;
    localparam int MAX_INFLIGHT    = 4;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 5 * 40;        // Five directed phases, 40 slots at most
    localparam int RANDOM_CYCLES   = 1500;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int WATCHDOG_TIME   = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    // Instruction kinds
    localparam int K_CALL    = 0;                   // JAL with link rd
    localparam int K_ICALL   = 1;                   // JALR with link rd
    localparam int K_RET     = 2;
    localparam int K_SWAP    = 3;                   // Coroutine swap
    localparam int K_BRANCH  = 4;
    localparam int K_ALU     = 5;
    localparam int K_JALR    = 6;                   // Indirect jump, no hints
    localparam int K_INVALID = 7;                   // Empty fetch slot

    logic            clk;
    logic            arst_n;
    logic            fetch_valid;
    logic [XLEN-1:0] fetch_pc;
    logic [31:0]     fetch_instr;
    logic            branch_retired;
    logic            fetch_flush;
    logic [XLEN-1:0] ras_addr;

    // Reference model state
    logic [XLEN-1:0] model_mem [RAS_ENTRIES];
    logic            model_written [RAS_ENTRIES];  // Entry holds a known address
    int              model_ptr;
    int              model_ckpt [MAX_INFLIGHT];    // Oldest checkpoint at index 0
    int              model_count;

    string           test_name;
    int              checks;
    int              errors;
    logic [XLEN-1:0] pc_cursor;                     // Next fetch address
    logic [XLEN-1:0] call_pc [32];

    return_predictor #(
        .RAS_ENTRIES  (RAS_ENTRIES),
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .branch_retired (branch_retired),
        .fetch_flush    (fetch_flush),
        .ras_addr       (ras_addr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic link_register(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);          // ra or t0
    endfunction

    function automatic logic [4:0] plain_register();
        logic [4:0] r;
        r = 5'($urandom);
        while (link_register(r)) begin
            r = 5'($urandom);
        end
        return r;
    endfunction

    function automatic logic [4:0] pick_link();
        return ($urandom_range(0, 1) == 0) ? 5'd1 : 5'd5;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_model();
        int i;
        model_ptr   = 0;
        model_count = 0;
        for (i = 0; i < RAS_ENTRIES; i++) begin
            model_written[i] = 1'b0;                // Contents undefined after reset
        end
    endtask

    task automatic step_model();
        logic [6:0] op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       is_call;
        logic       is_ret;
        logic       is_spec;
        int         base;
        int         nxt;
        int         i;
        op      = fetch_instr[6:0];
        rd      = fetch_instr[11:7];
        rs1     = fetch_instr[19:15];
        is_call = fetch_valid && (op == OPC_JAL || op == OPC_JALR) && link_register(rd);
        is_ret  = fetch_valid && (op == OPC_JALR) && link_register(rs1)
                  && !(link_register(rd) && rd == rs1);
        is_spec = fetch_valid && (op == OPC_BRANCH || op == OPC_JALR);
        base    = model_ptr;
        if (fetch_flush) begin
            if (model_count > 0) begin
                base = model_ckpt[0];               // Oldest surviving checkpoint
            end
            model_count = 0;                        // Same-cycle save is lost too
        end else begin
            if (branch_retired && model_count > 0) begin
                for (i = 0; i < MAX_INFLIGHT - 1; i++) begin
                    model_ckpt[i] = model_ckpt[i + 1];
                end
                model_count--;
            end
            if (is_spec && model_count < MAX_INFLIGHT) begin
                model_ckpt[model_count] = model_ptr;
                model_count++;
            end
        end
        nxt = (base + RAS_ENTRIES + int'(is_call) - int'(is_ret)) % RAS_ENTRIES;
        if (is_call) begin
            model_mem[nxt]     = fetch_pc + 32'd4;
            model_written[nxt] = 1'b1;
        end
        model_ptr = nxt;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            step_model();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_mismatch(input string what, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        errors++;
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic compare_model();
        checks++;
        if (int'(dut0.stack0.ptr) != model_ptr) begin
            report_mismatch("stack pointer", XLEN'(model_ptr), XLEN'(dut0.stack0.ptr));
        end
        if (model_written[model_ptr]) begin        // Never-written entries are skipped
            checks++;
            if (ras_addr !== model_mem[model_ptr]) begin
                report_mismatch("ras_addr vs model", model_mem[model_ptr], ras_addr);
            end
        end
    endtask

    task automatic wait_slot();
        @(negedge clk);                             // Outputs settled, inputs free to change
        compare_model();
    endtask

    task automatic drive(input int kind, input logic retire, input logic flush);
        int          k;
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [31:0] noise;
        k     = kind;
        noise = $urandom;
        rd    = plain_register();
        rs1   = plain_register();
        // A full checkpoint FIFO takes no new transfer unless it is flushed
        if (!flush && model_count >= MAX_INFLIGHT && k inside {[K_ICALL:K_BRANCH], K_JALR}) begin
            k = K_ALU;
        end
        opc = 7'b0010011;                           // OP-IMM
        case (k)
            K_CALL, K_INVALID: begin
                opc = OPC_JAL;
                rd  = pick_link();
            end
            K_ICALL: begin
                opc = OPC_JALR;
                rd  = pick_link();
                rs1 = noise[0] ? rd : rs1;          // Same link register is a plain call
            end
            K_RET: begin
                opc = OPC_JALR;
                rs1 = pick_link();
            end
            K_SWAP: begin
                opc = OPC_JALR;
                rd  = pick_link();
                rs1 = (rd == 5'd1) ? 5'd5 : 5'd1;
            end
            K_BRANCH: opc = OPC_BRANCH;
            K_JALR:   opc = OPC_JALR;
            default: ;
        endcase
        fetch_valid    = (k != K_INVALID);
        fetch_pc       = pc_cursor;
        fetch_instr    = {noise[31:20], rs1, noise[14:12], rd, opc};
        branch_retired = retire;
        fetch_flush    = flush;
        pc_cursor      = pc_cursor + 32'd4;
    endtask

    task automatic issue(input int kind, input logic retire, input logic flush);
        wait_slot();
        drive(kind, retire, flush);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic nested_calls();
        int i;
        test_name = "nested_calls";
        for (i = 0; i < 5; i++) begin
            call_pc[i] = pc_cursor;
            issue(K_CALL, 1'b0, 1'b0);
        end
        for (i = 4; i >= 0; i--) begin
            wait_slot();
            checks++;
            if (ras_addr !== call_pc[i] + 32'd4) begin
                report_mismatch("return target", call_pc[i] + 32'd4, ras_addr);
            end
            drive(K_RET, 1'b1, 1'b0);               // Retire keeps one checkpoint live
        end
    endtask

    task automatic overflow();
        int i;
        int total;
        test_name = "overflow";
        total     = RAS_ENTRIES + 3;                // Oldest three entries get overwritten
        for (i = 0; i < total; i++) begin
            call_pc[i] = pc_cursor;
            issue(K_CALL, 1'b1, 1'b0);
        end
        for (i = 0; i < RAS_ENTRIES; i++) begin
            wait_slot();
            checks++;
            if (ras_addr !== call_pc[total - 1 - i] + 32'd4) begin
                report_mismatch("wrapped return", call_pc[total - 1 - i] + 32'd4, ras_addr);
            end
            drive(K_RET, 1'b1, 1'b0);
        end
    endtask

    task automatic flush_recovery();
        logic [XLEN-1:0] good_pc;
        test_name = "flush_recovery";
        issue(K_ALU, 1'b1, 1'b1);                   // Start with no checkpoints
        good_pc = pc_cursor;
        issue(K_CALL, 1'b0, 1'b0);
        issue(K_BRANCH, 1'b0, 1'b0);                // Mispredicted later
        issue(K_CALL, 1'b0, 1'b0);                  // Wrong path from here
        issue(K_CALL, 1'b0, 1'b0);
        issue(K_RET, 1'b0, 1'b0);
        issue(K_CALL, 1'b0, 1'b0);
        issue(K_ALU, 1'b0, 1'b1);
        wait_slot();
        checks++;
        if (ras_addr !== good_pc + 32'd4) begin
            report_mismatch("restored top", good_pc + 32'd4, ras_addr);
        end
        drive(K_ALU, 1'b0, 1'b0);
    endtask

    task automatic retirement();
        logic [XLEN-1:0] pc_b;
        logic [XLEN-1:0] pc_d;
        test_name = "retirement";
        issue(K_ALU, 1'b1, 1'b1);
        issue(K_CALL, 1'b0, 1'b0);
        issue(K_BRANCH, 1'b0, 1'b0);                // Checkpoint one
        pc_b = pc_cursor;
        issue(K_CALL, 1'b0, 1'b0);
        issue(K_BRANCH, 1'b0, 1'b0);                // Checkpoint two
        issue(K_ALU, 1'b1, 1'b0);                   // First branch retires
        issue(K_CALL, 1'b0, 1'b0);
        issue(K_ALU, 1'b0, 1'b1);                   // Back to checkpoint two
        wait_slot();
        checks++;
        if (ras_addr !== pc_b + 32'd4) begin
            report_mismatch("oldest unretired", pc_b + 32'd4, ras_addr);
        end
        pc_d = pc_cursor;
        drive(K_CALL, 1'b0, 1'b0);
        issue(K_ALU, 1'b0, 1'b1);                   // No checkpoints left
        wait_slot();
        checks++;
        if (ras_addr !== pc_d + 32'd4) begin
            report_mismatch("flush without checkpoint", pc_d + 32'd4, ras_addr);
        end
        drive(K_ALU, 1'b0, 1'b0);
    endtask

    task automatic decode_rules();
        logic [XLEN-1:0] pc_a;
        logic [XLEN-1:0] pc_s;
        test_name = "decode_rules";
        issue(K_ALU, 1'b1, 1'b1);
        pc_a = pc_cursor;
        issue(K_CALL, 1'b1, 1'b0);
        issue(K_CALL, 1'b1, 1'b0);
        pc_s = pc_cursor;
        issue(K_SWAP, 1'b1, 1'b0);                  // Pop and push in one slot
        wait_slot();
        checks++;
        if (ras_addr !== pc_s + 32'd4) begin
            report_mismatch("coroutine swap", pc_s + 32'd4, ras_addr);
        end
        drive(K_RET, 1'b1, 1'b0);
        wait_slot();
        checks++;
        if (ras_addr !== pc_a + 32'd4) begin
            report_mismatch("return after swap", pc_a + 32'd4, ras_addr);
        end
        drive(K_JALR, 1'b1, 1'b0);
        wait_slot();
        checks++;
        if (ras_addr !== pc_a + 32'd4) begin
            report_mismatch("non-link jalr", pc_a + 32'd4, ras_addr);
        end
        drive(K_INVALID, 1'b1, 1'b0);               // Call encoding in an empty slot
        wait_slot();
        checks++;
        if (ras_addr !== pc_a + 32'd4) begin
            report_mismatch("invalid fetch", pc_a + 32'd4, ras_addr);
        end
        drive(K_ALU, 1'b1, 1'b0);
    endtask

    task automatic random_mix();
        int i;
        test_name = "random_mix";
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            if ($urandom_range(0, 15) == 0) begin
                pc_cursor = $urandom & 32'hffff_fffc;   // Taken jump somewhere else
            end
            issue(int'($urandom_range(0, 7)), ($urandom_range(0, 2) == 0),
                  ($urandom_range(0, 15) == 0));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        arst_n         = 1'b0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        fetch_instr    = '0;
        branch_retired = 1'b0;
        fetch_flush    = 1'b0;
        pc_cursor      = 32'h0000_1000;
        checks         = 0;
        errors         = 0;
        test_name      = "reset";
        void'($urandom(32'h59c));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        nested_calls();
        overflow();
        flush_recovery();
        retirement();
        decode_rules();
        random_mix();
        wait_slot();                                // Result of the last slot
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.stack0.ckpt_fifo0.assert0.failures);
        if (errors == 0 && dut0.stack0.ckpt_fifo0.assert0.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/return_predictor_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checkpoint FIFO assertions
// Occupancy rules of the saved stack pointers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module return_predictor_assertions (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic clear,
    input wire logic push,
    input wire logic valid,
    input wire logic full
);

    int failures = 0;                               // Failed assertion count

    // More unretired transfers than slots
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (full && !clear) |-> !push
    ) else begin
        failures++;
        $error("checkpoint saved into a full FIFO");
    end

    // A retire on an empty FIFO would wrap the occupancy
    no_underflow_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!valid && !push) |=> !valid
    ) else begin
        failures++;
        $error("checkpoint FIFO underflowed while empty");
    end

    // Flush leaves no checkpoint behind
    empty_after_clear: assert property (
        @(posedge clk) disable iff (!arst_n)
        clear |=> !valid
    ) else begin
        failures++;
        $error("checkpoint FIFO not empty after a clear");
    end

endmodule

bind ras_checkpoint_fifo return_predictor_assertions assert0 (
    .clk    (clk),
    .arst_n (arst_n),
    .clear  (clear),
    .push   (push),
    .valid  (valid),
    .full   (full)
);

`default_nettype wire

// ==== hw/return_predictor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Return address predictor top
// Decoder feeding the checkpointed return stack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module return_predictor
    import ras_pkg::*;
#(
    parameter int RAS_ENTRIES  = 8,             // Stack depth, power of two
    parameter int MAX_INFLIGHT = 4              // Unretired speculative limit
) (
    input  wire logic            clk,
    input  wire logic            arst_n,
    // Fetch side
    input  wire logic            fetch_valid,
    input  wire logic [XLEN-1:0] fetch_pc,
    input  wire logic [31:0]     fetch_instr,
    // Retire and recovery
    input  wire logic            branch_retired, // One checkpoint retired
    input  wire logic            fetch_flush,    // Mispredict recovery
    // Prediction
    output logic      [XLEN-1:0] ras_addr
);

    logic            call;
    logic            ret;
    logic            spec;
    logic [XLEN-1:0] link_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    call_return_decode decode0 (
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .call        (call),
        .ret         (ret),
        .spec        (spec),
        .link_addr   (link_addr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stack
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode effect shows on ras_addr one cycle after fetch
    return_stack #(
        .RAS_ENTRIES  (RAS_ENTRIES),
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) stack0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .push           (call),
        .pop            (ret),
        .push_addr      (link_addr),
        .save           (spec),
        .branch_retired (branch_retired),
        .fetch_flush    (fetch_flush),
        .ras_addr       (ras_addr)
    );

endmodule

`default_nettype wire

// ==== hw/return_stack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular return stack
// Pointer checkpoint on speculation, restore on flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module return_stack
    import ras_pkg::*;
#(
    parameter int RAS_ENTRIES  = 8,             // Stack depth, power of two
    parameter int MAX_INFLIGHT = 4              // Checkpoint FIFO depth
) (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            push,          // Call
    input  wire logic            pop,           // Return
    input  wire logic [XLEN-1:0] push_addr,     // Link address to store
    input  wire logic            save,          // Speculative transfer fetched
    input  wire logic            branch_retired,
    input  wire logic            fetch_flush,
    output logic      [XLEN-1:0] ras_addr       // Predicted return target
);

    localparam int IDX_W = $clog2(RAS_ENTRIES);

    logic [XLEN-1:0]  mem [RAS_ENTRIES];        // Return addresses, no reset
    logic [IDX_W-1:0] ptr;                      // Current top of stack
    logic [IDX_W-1:0] ptr_base;
    logic [IDX_W-1:0] ptr_next;
    logic [IDX_W-1:0] ckpt_head;                // Oldest saved pointer
    logic             ckpt_valid;
    logic             ckpt_pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checkpoints
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire only drops an entry that exists
    assign ckpt_pop = branch_retired & ckpt_valid;

    ras_checkpoint_fifo #(
        .DEPTH  (MAX_INFLIGHT),
        .DATA_W (IDX_W)
    ) ckpt_fifo0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .clear    (fetch_flush),                // Flush discards all checkpoints
        .push     (save),
        .pop      (ckpt_pop),
        .data_in  (ptr),                        // Pointer before this fetch
        .data_out (ckpt_head),
        .valid    (ckpt_valid),
        .full     ()                            // Checked only by assertions
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointer update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Restore from the oldest surviving checkpoint, else keep going
    assign ptr_base = (fetch_flush && ckpt_valid) ? ckpt_head : ptr;

    // Wraps modulo RAS_ENTRIES, so overflow loses the oldest entries
    assign ptr_next = ptr_base + IDX_W'(push) - IDX_W'(pop);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else begin
            ptr <= ptr_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (push) begin
            mem[ptr_next] <= push_addr;         // Swap overwrites the old top
        end
    end

    assign ras_addr = mem[ptr];                 // Top always offered

endmodule

`default_nettype wire

// ==== hw/ras_checkpoint_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checkpoint FIFO
// Holds saved stack pointers in fetch order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ras_checkpoint_fifo #(
    parameter int DEPTH  = 4,                   // Max unretired transfers
    parameter int DATA_W = 3                    // Stack index width
) (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              clear,       // Drop all entries
    input  wire logic              push,
    input  wire logic              pop,
    input  wire logic [DATA_W-1:0] data_in,
    output logic      [DATA_W-1:0] data_out,    // Oldest entry
    output logic                   valid,       // Not empty
    output logic                   full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];             // Payload, no reset
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;                   // Occupancy

    // Pointer advance with wrap at DEPTH
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        n = (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (push && !clear) begin
            mem[wr_ptr] <= data_in;             // Save lost on a clear cycle
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin               // Clear wins over push and pop
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);    // Both may happen
        end
    end

    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== hw/call_return_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Call / return decoder
// Classifies a fetched instruction for the return stack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module call_return_decode
    import ras_pkg::*;
(
    input  wire logic            fetch_valid,   // Fetch slot holds an instruction
    input  wire logic [XLEN-1:0] fetch_pc,      // Address of the instruction
    input  wire logic [31:0]     fetch_instr,   // Raw instruction word
    output logic                 call,          // Push the link address
    output logic                 ret,           // Pop the stack
    output logic                 spec,          // Save a checkpoint
    output logic [XLEN-1:0]      link_addr      // pc+4
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [OPC_W-1:0] opcode;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic             is_jal;
    logic             is_jalr;
    logic             is_branch;
    logic             rd_link;
    logic             rs1_link;

    assign opcode = fetch_instr[OPC_W-1:0];
    assign rd     = fetch_instr[RD_LSB +: REG_W];
    assign rs1    = fetch_instr[RS1_LSB +: REG_W];

    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);
    assign is_branch = (opcode == OPC_BRANCH);  // Any B-type

    // Hint bits of the calling convention
    assign rd_link  = is_link_reg(rd);
    assign rs1_link = is_link_reg(rs1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // JAL/JALR writing a link register is a call
    assign call = fetch_valid & (is_jal | is_jalr) & rd_link;

    // JALR through a link register pops, unless rd is the same link register
    // Two different link registers give pop and push together (coroutine swap)
    assign ret = fetch_valid & is_jalr & rs1_link & (~rd_link | (rd != rs1));

    // Conditional branches and indirect jumps can be mispredicted
    assign spec = fetch_valid & (is_branch | is_jalr);

    // Return address of a call
    assign link_addr = fetch_valid ? (fetch_pc + XLEN'(4)) : '0;

endmodule

`default_nettype wire

// ==== hw/ras_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Return predictor shared definitions
// Address width, RISC-V opcodes and instruction fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ras_pkg;

    localparam int XLEN = 32;                       // Address width

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPC_W   = 7;                     // Major opcode width
    localparam int REG_W   = 5;                     // Register specifier width
    localparam int RD_LSB  = 7;                     // rd at [11:7]
    localparam int RS1_LSB = 15;                    // rs1 at [19:15]

    // Major opcodes of the control transfers
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;

    // Link registers of the calling convention
    localparam logic [REG_W-1:0] LINK_X1 = 5'd1;    // ra
    localparam logic [REG_W-1:0] LINK_X5 = 5'd5;    // t0, alternate link

    // True for x1 or x5
    function automatic logic is_link_reg(input logic [REG_W-1:0] r);
        logic hit;
        hit = (r == LINK_X1) || (r == LINK_X5);
        return hit;
    endfunction

endpackage

`default_nettype wire
